/* logic/mipsPkg.sv */
`default_nettype none

package mipsPkg;

    typedef logic [31:0] word_t;      // data word, address or instruction
    typedef logic [4:0]  regAddr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [2:0]  aluSel_t;
    typedef logic [1:0]  fwdSel_t;

    //////////////////////////////
    // opcodes
    localparam opcode_t opRType = 6'h00;
    localparam opcode_t opJ     = 6'h02;
    localparam opcode_t opBeq   = 6'h04;
    localparam opcode_t opAddi  = 6'h08;
    localparam opcode_t opOri   = 6'h0D;
    localparam opcode_t opHalt  = 6'h0E;
    localparam opcode_t opLui   = 6'h0F;
    localparam opcode_t opLw    = 6'h23;
    localparam opcode_t opSw    = 6'h2B;

    // function field of R-type
    localparam funct_t fnAdd = 6'h20;
    localparam funct_t fnSub = 6'h22;
    localparam funct_t fnAnd = 6'h24;
    localparam funct_t fnOr  = 6'h25;
    localparam funct_t fnSlt = 6'h2A;

    localparam aluSel_t aluAnd = 3'b000;
    localparam aluSel_t aluOr  = 3'b001;
    localparam aluSel_t aluAdd = 3'b010;
    localparam aluSel_t aluSub = 3'b110;
    localparam aluSel_t aluSlt = 3'b111;

    localparam fwdSel_t fwdNone      = 2'b00;
    localparam fwdSel_t fwdWriteback = 2'b01;
    localparam fwdSel_t fwdMemory    = 2'b10;

    localparam int ledAddrBit = 31;    // set means LED region

    //////////////////////////////
    // pipeline registers
    typedef struct packed {
        logic    regWrite;
        logic    aluSrcImm;
        logic    memWrite;
        logic    memToReg;
        logic    immToReg;    // lui
        aluSel_t aluSel;
        logic    branch;      // beq, resolved in decode
        logic    jump;
        logic    halt;
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    rsData;
        word_t    rtData;
        word_t    imm;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t dest;
    } idEx_t;

    typedef struct packed {
        logic     regWrite;
        logic     memWrite;
        logic     memToReg;
        logic     halt;
        word_t    aluRes;
        word_t    storeData;
        regAddr_t dest;
    } exMem_t;

    typedef struct packed {
        logic     regWrite;
        logic     memToReg;
        logic     halt;
        word_t    aluRes;
        word_t    loadData;
        regAddr_t dest;
    } memWb_t;

endpackage

`default_nettype wire

/* logic/fetchStage.sv */
`default_nettype none

module fetchStage #(
    parameter mipsPkg::word_t resetVector = 32'h0040_0000
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           stall,
    input  logic           branchTaken,
    input  logic           jump,
    input  mipsPkg::word_t pcBranch,
    input  mipsPkg::word_t pcJump,
    input  mipsPkg::word_t instr,
    output mipsPkg::word_t instrAddress,
    output mipsPkg::word_t instrD,
    output mipsPkg::word_t pcPlus4D
);

    mipsPkg::word_t pcPlus4;
    mipsPkg::word_t pcNext;

    assign pcPlus4 = instrAddress + 32'd4;
    assign pcNext  = branchTaken ? pcBranch : (jump ? pcJump : pcPlus4);

    // a redirect only counts once decode is free to move
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            instrAddress <= resetVector;
            instrD       <= '0;
            pcPlus4D     <= '0;
        end
        else if (!stall)
        begin
            instrAddress <= pcNext;
            pcPlus4D     <= pcPlus4;
            instrD       <= (branchTaken || jump) ? '0 : instr;    // squash, no delay slot
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (reset) instrAddress[1:0] == 2'b00)
        else $error("fetch: pc %h not word aligned", instrAddress);

endmodule

`default_nettype wire

/* logic/decodeStage.sv */
`default_nettype none

module decodeStage (
    input  logic              clk,
    input  logic              reset,
    input  logic              flushE,
    input  logic              fwdAD,
    input  logic              fwdBD,
    input  mipsPkg::word_t    instrD,
    input  mipsPkg::word_t    pcPlus4D,
    input  mipsPkg::word_t    aluResM,
    input  mipsPkg::word_t    regWriteData,
    input  mipsPkg::memWb_t   memWb,
    output mipsPkg::ctrl_t    ctrlD,
    output mipsPkg::idEx_t    idEx,
    output logic              branchTaken,
    output logic              jump,
    output mipsPkg::word_t    pcBranch,
    output mipsPkg::word_t    pcJump
);

    mipsPkg::word_t    regs [32];
    mipsPkg::opcode_t  opcode;
    mipsPkg::funct_t   funct;
    mipsPkg::regAddr_t rs, rt, dest;
    mipsPkg::word_t    rsData, rtData, imm, cmpA, cmpB;
    logic              regDst, zeroImm;

    assign opcode = instrD[31:26];
    assign funct  = instrD[5:0];
    assign rs     = instrD[25:21];
    assign rt     = instrD[20:16];

    //////////////////////////////
    // control decode
    always_comb
    begin
        ctrlD   = '0;
        regDst  = 1'b0;
        zeroImm = 1'b0;
        case (opcode)
            mipsPkg::opRType:
            begin
                regDst         = 1'b1;
                ctrlD.regWrite = 1'b1;
                case (funct)
                    mipsPkg::fnAdd: ctrlD.aluSel = mipsPkg::aluAdd;
                    mipsPkg::fnSub: ctrlD.aluSel = mipsPkg::aluSub;
                    mipsPkg::fnAnd: ctrlD.aluSel = mipsPkg::aluAnd;
                    mipsPkg::fnOr:  ctrlD.aluSel = mipsPkg::aluOr;
                    mipsPkg::fnSlt: ctrlD.aluSel = mipsPkg::aluSlt;
                    default:        ctrlD.regWrite = 1'b0;    // unknown funct, nop
                endcase
            end
            mipsPkg::opAddi, mipsPkg::opLw, mipsPkg::opSw:
            begin
                ctrlD.aluSrcImm = 1'b1;
                ctrlD.aluSel    = mipsPkg::aluAdd;
                ctrlD.regWrite  = (opcode != mipsPkg::opSw);
                ctrlD.memToReg  = (opcode == mipsPkg::opLw);
                ctrlD.memWrite  = (opcode == mipsPkg::opSw);
            end
            mipsPkg::opOri:
            begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.aluSrcImm = 1'b1;
                ctrlD.aluSel    = mipsPkg::aluOr;
                zeroImm         = 1'b1;
            end
            mipsPkg::opLui:
            begin
                ctrlD.regWrite = 1'b1;
                ctrlD.immToReg = 1'b1;
            end
            mipsPkg::opBeq:  ctrlD.branch = 1'b1;
            mipsPkg::opJ:    ctrlD.jump = 1'b1;
            mipsPkg::opHalt: ctrlD.halt = 1'b1;
            default: ;
        endcase
    end

    // register file, write-through from writeback
    always_ff @(posedge clk)
    begin
        if (memWb.regWrite && memWb.dest != '0)
            regs[memWb.dest] <= regWriteData;
    end

    function automatic mipsPkg::word_t readReg(mipsPkg::regAddr_t a);
        if (a == '0)
            return '0;
        if (memWb.regWrite && memWb.dest == a)
            return regWriteData;
        return regs[a];
    endfunction

    always_comb
    begin
        rsData = readReg(rs);
        rtData = readReg(rt);
    end

    assign imm  = zeroImm ? {16'd0, instrD[15:0]} : {{16{instrD[15]}}, instrD[15:0]};
    assign dest = regDst ? instrD[15:11] : rt;

    // branch compare sees the memory-stage result
    assign cmpA        = fwdAD ? aluResM : rsData;
    assign cmpB        = fwdBD ? aluResM : rtData;
    assign branchTaken = ctrlD.branch && (cmpA == cmpB);
    assign jump        = ctrlD.jump;
    assign pcBranch    = pcPlus4D + {imm[29:0], 2'b00};
    assign pcJump      = {pcPlus4D[31:28], instrD[25:0], 2'b00};

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            idEx <= '0;
        else if (flushE)
            idEx <= '0;    // bubble
        else
        begin
            idEx.ctrl   <= ctrlD;
            idEx.rsData <= rsData;
            idEx.rtData <= rtData;
            idEx.imm    <= imm;
            idEx.rs     <= rs;
            idEx.rt     <= rt;
            idEx.dest   <= dest;
        end
    end

endmodule

`default_nettype wire

/* logic/executeStage.sv */
`default_nettype none

module executeStage (
    input  logic             clk,
    input  logic             reset,
    input  mipsPkg::idEx_t   idEx,
    input  mipsPkg::fwdSel_t fwdA,
    input  mipsPkg::fwdSel_t fwdB,
    input  mipsPkg::word_t   aluResM,
    input  mipsPkg::word_t   regWriteData,
    output mipsPkg::exMem_t  exMem
);

    mipsPkg::word_t srcA, srcB, storeData, aluOut, result;

    function automatic mipsPkg::word_t pickOperand(mipsPkg::fwdSel_t sel,
        mipsPkg::word_t regVal, mipsPkg::word_t memVal, mipsPkg::word_t wbVal);
        case (sel)
            mipsPkg::fwdMemory:    return memVal;
            mipsPkg::fwdWriteback: return wbVal;
            default:               return regVal;
        endcase
    endfunction

    assign srcA      = pickOperand(fwdA, idEx.rsData, aluResM, regWriteData);
    assign storeData = pickOperand(fwdB, idEx.rtData, aluResM, regWriteData);
    assign srcB      = idEx.ctrl.aluSrcImm ? idEx.imm : storeData;

    always_comb
    begin
        case (idEx.ctrl.aluSel)
            mipsPkg::aluAnd: aluOut = srcA & srcB;
            mipsPkg::aluOr:  aluOut = srcA | srcB;
            mipsPkg::aluAdd: aluOut = srcA + srcB;
            mipsPkg::aluSub: aluOut = srcA - srcB;
            mipsPkg::aluSlt: aluOut = {31'd0, $signed(srcA) < $signed(srcB)};
            default:         aluOut = '0;
        endcase
    end

    // lui skips the alu
    assign result = idEx.ctrl.immToReg ? {idEx.imm[15:0], 16'd0} : aluOut;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            exMem <= '0;
        else
        begin
            exMem.regWrite  <= idEx.ctrl.regWrite;
            exMem.memWrite  <= idEx.ctrl.memWrite;
            exMem.memToReg  <= idEx.ctrl.memToReg;
            exMem.halt      <= idEx.ctrl.halt;
            exMem.aluRes    <= result;
            exMem.storeData <= storeData;    // already forwarded
            exMem.dest      <= idEx.dest;
        end
    end

endmodule

`default_nettype wire

/* logic/memoryStage.sv */
`default_nettype none

module memoryStage #(
    parameter int ledCount = 3
) (
    input  logic                clk,
    input  logic                reset,
    input  mipsPkg::exMem_t     exMem,
    input  mipsPkg::word_t      dataReadData,
    output mipsPkg::word_t      dataAddress,
    output mipsPkg::word_t      dataWriteData,
    output logic                dataWriteEnable,
    output logic [ledCount-1:0] led,
    output mipsPkg::memWb_t     memWb,
    output mipsPkg::word_t      regWriteData,
    output logic                halt
);

    logic ledRegion;

    assign ledRegion       = exMem.aluRes[mipsPkg::ledAddrBit];
    assign dataAddress     = exMem.aluRes;
    assign dataWriteData   = exMem.storeData;
    assign dataWriteEnable = exMem.memWrite && !ledRegion;

    //////////////////////////////
    // led k sits at word k of the region
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            led <= '0;
        else if (exMem.memWrite && ledRegion)
        begin
            for (int k = 0; k < ledCount; k++)
            begin
                if (exMem.aluRes[3:0] == 4'(4 * k))
                    led[k] <= exMem.storeData[0];
            end
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            memWb <= '0;
        else
        begin
            memWb.regWrite <= exMem.regWrite;
            memWb.memToReg <= exMem.memToReg;
            memWb.halt     <= exMem.halt;
            memWb.aluRes   <= exMem.aluRes;
            memWb.loadData <= ledRegion ? '0 : dataReadData;    // led reads as zero
            memWb.dest     <= exMem.dest;
        end
    end

    assign regWriteData = memWb.memToReg ? memWb.loadData : memWb.aluRes;

    // sticky until reset
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            halt <= 1'b0;
        else if (memWb.halt)
            halt <= 1'b1;
    end

    noBusWriteAfterHalt: assert property (@(posedge clk) disable iff (reset)
        halt |-> !dataWriteEnable)
        else $error("memory: bus write at %h after halt", dataAddress);

endmodule

`default_nettype wire

/* logic/hazardUnit.sv */
`default_nettype none

module hazardUnit (
    input  mipsPkg::regAddr_t rsD,
    input  mipsPkg::regAddr_t rtD,
    input  mipsPkg::ctrl_t    ctrlD,
    input  mipsPkg::idEx_t    idEx,
    input  mipsPkg::exMem_t   exMem,
    input  mipsPkg::memWb_t   memWb,
    input  logic              halt,
    output mipsPkg::fwdSel_t  fwdA,
    output mipsPkg::fwdSel_t  fwdB,
    output logic              fwdAD,
    output logic              fwdBD,
    output logic              stall,
    output logic              flushE
);

    logic rtUsed, lwStall, branchStall, haltPending, haltOnly;

    // memory stage wins over writeback
    function automatic mipsPkg::fwdSel_t pickFwd(mipsPkg::regAddr_t src);
        if (src != '0 && exMem.regWrite && exMem.dest == src)
            return mipsPkg::fwdMemory;
        if (src != '0 && memWb.regWrite && memWb.dest == src)
            return mipsPkg::fwdWriteback;
        return mipsPkg::fwdNone;
    endfunction

    always_comb
    begin
        fwdA = pickFwd(idEx.rs);
        fwdB = pickFwd(idEx.rt);
    end

    assign fwdAD = rsD != '0 && exMem.regWrite && exMem.dest == rsD;
    assign fwdBD = rtD != '0 && exMem.regWrite && exMem.dest == rtD;

    //////////////////////////////
    // stalls
    assign rtUsed  = (!ctrlD.aluSrcImm && !ctrlD.jump) || ctrlD.memWrite;    // sw data too
    assign lwStall = idEx.ctrl.memToReg && idEx.dest != '0 &&
                     (idEx.dest == rsD || (rtUsed && idEx.dest == rtD));

    // compare needs the value by the memory stage, and not a load there
    assign branchStall = ctrlD.branch &&
        ((idEx.ctrl.regWrite && idEx.dest != '0 && (idEx.dest == rsD || idEx.dest == rtD)) ||
         (exMem.memToReg && exMem.dest != '0 && (exMem.dest == rsD || exMem.dest == rtD)));

    assign haltPending = ctrlD.halt || idEx.ctrl.halt || exMem.halt || memWb.halt || halt;
    assign haltOnly    = haltPending && !lwStall && !branchStall;

    assign stall  = lwStall || branchStall || haltPending;
    assign flushE = lwStall || branchStall || ctrlD.jump;

    // a held halt keeps feeding itself into execute, never a bubble
    always_comb
    begin
        assert final (!(flushE && haltOnly))
            else $error("hazard: flush during halt stall");
    end

endmodule

`default_nettype wire

/* logic/mipsSystem.sv */
`default_nettype none

module mipsSystem #(
    parameter mipsPkg::word_t resetVector = 32'h0040_0000,
    parameter int             ledCount    = 3
) (
    input  logic                clk,
    input  logic                reset,
    input  mipsPkg::word_t      instr,
    input  mipsPkg::word_t      dataReadData,
    output mipsPkg::word_t      instrAddress,
    output mipsPkg::word_t      dataAddress,
    output mipsPkg::word_t      dataWriteData,
    output logic                dataWriteEnable,
    output logic                halt,
    output logic [ledCount-1:0] led
);

    mipsPkg::word_t   instrD, pcPlus4D, pcBranch, pcJump, regWriteData;
    logic             branchTaken, jump, stall, flushE, fwdAD, fwdBD;
    mipsPkg::fwdSel_t fwdA, fwdB;
    mipsPkg::ctrl_t   ctrlD;
    mipsPkg::idEx_t   idEx;
    mipsPkg::exMem_t  exMem;
    mipsPkg::memWb_t  memWb;

    fetchStage #(.resetVector(resetVector)) u_fetch (
        .clk, .reset, .stall, .branchTaken, .jump, .pcBranch, .pcJump,
        .instr, .instrAddress, .instrD, .pcPlus4D
    );

    decodeStage u_decode (
        .clk, .reset, .flushE, .fwdAD, .fwdBD, .instrD, .pcPlus4D,
        .aluResM(exMem.aluRes), .regWriteData, .memWb, .ctrlD, .idEx,
        .branchTaken, .jump, .pcBranch, .pcJump
    );

    executeStage u_execute (
        .clk, .reset, .idEx, .fwdA, .fwdB,
        .aluResM(exMem.aluRes), .regWriteData, .exMem
    );

    memoryStage #(.ledCount(ledCount)) u_memory (
        .clk, .reset, .exMem, .dataReadData, .dataAddress, .dataWriteData,
        .dataWriteEnable, .led, .memWb, .regWriteData, .halt
    );

    // rs and rt straight from the decode instruction
    hazardUnit u_hazard (
        .rsD(instrD[25:21]), .rtD(instrD[20:16]), .ctrlD, .idEx, .exMem, .memWb,
        .halt, .fwdA, .fwdB, .fwdAD, .fwdBD, .stall, .flushE
    );

endmodule

`default_nettype wire

/* include/tbEncode.svh */
`ifndef TBENCODE_SVH
`define TBENCODE_SVH

// shamt stays zero
function automatic mipsPkg::word_t encR(input mipsPkg::funct_t funct,
    input mipsPkg::regAddr_t rd, input mipsPkg::regAddr_t rs, input mipsPkg::regAddr_t rt);
    return {mipsPkg::opRType, rs, rt, rd, 5'd0, funct};
endfunction

// addi, ori, lui, lw, sw and beq
function automatic mipsPkg::word_t encI(input mipsPkg::opcode_t op,
    input mipsPkg::regAddr_t rt, input mipsPkg::regAddr_t rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic mipsPkg::word_t encJ(input mipsPkg::word_t target);
    return {mipsPkg::opJ, target[27:2]};    // byte address in, word index out
endfunction

function automatic mipsPkg::word_t encHalt();
    return {mipsPkg::opHalt, 26'd0};
endfunction

// all-zero word decodes as a nop
function automatic mipsPkg::word_t encNop();
    return '0;
endfunction

`endif

/* test/tbMipsSystem.sv */
`default_nettype none

module tbMipsSystem;

    localparam mipsPkg::word_t resetVector = 32'h0040_0000;
    localparam int             ledCount    = 3;
    localparam int             progWords   = 256;
    localparam int             haltLimit   = 2000;    // cycles

    logic                clk;
    logic                reset;
    mipsPkg::word_t      instr        = '0;
    mipsPkg::word_t      dataReadData = '0;
    mipsPkg::word_t      instrAddress;
    mipsPkg::word_t      dataAddress;
    mipsPkg::word_t      dataWriteData;
    logic                dataWriteEnable;
    logic                halt;
    logic [ledCount-1:0] led;

    mipsPkg::word_t imem [progWords];
    mipsPkg::word_t dmem [mipsPkg::word_t];    // sparse, keyed by byte address
    int             progLen;
    int             spacing;
    int             logStart;
    mipsPkg::word_t logAddr[$];
    mipsPkg::word_t logData[$];
    mipsPkg::word_t expAddr[$];
    mipsPkg::word_t expData[$];
    int             mismatches;
    int             failures;

    `include "tbEncode.svh"

    mipsSystem #(.resetVector(resetVector), .ledCount(ledCount)) u_dut (
        .clk, .reset, .instr, .dataReadData, .instrAddress, .dataAddress,
        .dataWriteData, .dataWriteEnable, .halt, .led
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // contents of a data word never stored to
    function automatic mipsPkg::word_t fillPattern(input mipsPkg::word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;
    endfunction

    // two's complement order, sign bits decide when they differ
    function automatic logic signedLess(input mipsPkg::word_t x, input mipsPkg::word_t y);
        if (x[31] != y[31])
            return x[31];
        return x < y;
    endfunction

    //////////////////////////////
    // memory models
    always @(negedge clk)
    begin
        mipsPkg::word_t offset;
        if (!reset && dataWriteEnable)
        begin
            logAddr.push_back(dataAddress);
            logData.push_back(dataWriteData);
            dmem[dataAddress] = dataWriteData;
        end
        offset = instrAddress - resetVector;
        instr = (offset < mipsPkg::word_t'(4 * progWords)) ? imem[offset[9:2]] : encNop();
        dataReadData = dmem.exists(dataAddress) ? dmem[dataAddress] : fillPattern(dataAddress);
    end

    //////////////////////////////
    // compare tasks
    task automatic checkWord(input string name, input mipsPkg::word_t got,
        input mipsPkg::word_t exp);
        if (got !== exp)
        begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic checkLed(input string name, input logic [ledCount-1:0] got,
        input logic [ledCount-1:0] exp);
        if (got !== exp)
        begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    //////////////////////////////
    // program building
    task automatic clearProgram(input int nopsAfter);
        for (int i = 0; i < progWords; i++)
            imem[i] = encNop();
        progLen = 0;
        spacing = nopsAfter;    // nops after each word
        expAddr.delete();
        expData.delete();
    endtask

    task automatic emit(input mipsPkg::word_t word);
        imem[progLen] = word;
        progLen++;
        repeat (spacing)
        begin
            imem[progLen] = encNop();
            progLen++;
        end
    endtask

    task automatic loadConst(input mipsPkg::regAddr_t r, input mipsPkg::word_t value);
        emit(encI(mipsPkg::opLui, r, 5'd0, value[31:16]));
        emit(encI(mipsPkg::opOri, r, r, value[15:0]));
    endtask

    task automatic storeAndExpect(input mipsPkg::regAddr_t src, input logic [15:0] addr,
        input mipsPkg::word_t expected);
        emit(encI(mipsPkg::opSw, src, 5'd0, addr));
        expAddr.push_back({16'd0, addr});
        expData.push_back(expected);
    endtask

    task automatic checkStores(input string testName);
        int count;
        count = logAddr.size() - logStart;
        checkWord({testName, " store count"}, mipsPkg::word_t'(count),
            mipsPkg::word_t'(expAddr.size()));
        for (int i = 0; i < expAddr.size() && i < count; i++)
        begin
            checkWord($sformatf("%s store %0d address", testName, i),
                logAddr[logStart + i], expAddr[i]);
            checkWord($sformatf("%s store %0d data", testName, i),
                logData[logStart + i], expData[i]);
        end
    endtask

    // reset, run to halt, then watch the frozen state
    task automatic runProgram(input string testName);
        int             cycles;
        mipsPkg::word_t pcAtHalt;
        @(negedge clk);
        reset = 1'b1;
        repeat (16) @(negedge clk);
        checkFlag("halt in reset", halt, 1'b0);
        checkFlag("dataWriteEnable in reset", dataWriteEnable, 1'b0);
        checkLed("led in reset", led, '0);
        checkWord("instrAddress in reset", instrAddress, resetVector);
        logStart = logAddr.size();
        reset    = 1'b0;
        cycles   = 0;
        while (!halt && cycles < haltLimit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!halt)
        begin
            $display("%s: no halt within %0d cycles", testName, haltLimit);
            failures++;
        end
        else
        begin
            pcAtHalt = instrAddress;
            repeat (8)
            begin
                @(negedge clk);
                checkFlag({testName, " halt held"}, halt, 1'b1);
                checkWord({testName, " instrAddress after halt"}, instrAddress, pcAtHalt);
            end
            checkStores(testName);
        end
    endtask

    //////////////////////////////
    // directed tests
    task automatic arithmeticTest();
        mipsPkg::word_t a, b;
        logic [15:0]    immAdd, immOr, immLui;
        a      = $urandom();
        b      = $urandom();
        immAdd = 16'($urandom());
        immOr  = 16'($urandom());
        immLui = 16'($urandom());
        clearProgram(0);
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        emit(encR(mipsPkg::fnAdd, 5'd3, 5'd1, 5'd2));
        storeAndExpect(5'd3, 16'h0100, a + b);
        emit(encR(mipsPkg::fnSub, 5'd4, 5'd1, 5'd2));
        storeAndExpect(5'd4, 16'h0104, a - b);
        emit(encR(mipsPkg::fnAnd, 5'd5, 5'd1, 5'd2));
        storeAndExpect(5'd5, 16'h0108, a & b);
        emit(encR(mipsPkg::fnOr, 5'd6, 5'd1, 5'd2));
        storeAndExpect(5'd6, 16'h010C, a | b);
        emit(encR(mipsPkg::fnSlt, 5'd7, 5'd1, 5'd2));
        storeAndExpect(5'd7, 16'h0110, {31'd0, signedLess(a, b)});
        emit(encR(mipsPkg::fnSlt, 5'd8, 5'd2, 5'd1));
        storeAndExpect(5'd8, 16'h0114, {31'd0, signedLess(b, a)});
        emit(encI(mipsPkg::opAddi, 5'd9, 5'd1, immAdd));
        storeAndExpect(5'd9, 16'h0118, a + {{16{immAdd[15]}}, immAdd});
        emit(encI(mipsPkg::opOri, 5'd10, 5'd1, immOr));
        storeAndExpect(5'd10, 16'h011C, a | {16'd0, immOr});
        emit(encI(mipsPkg::opLui, 5'd11, 5'd0, immLui));
        storeAndExpect(5'd11, 16'h0120, {immLui, 16'd0});
        emit(encHalt());
        runProgram("arithmetic");
    endtask

    // same program packed tight, then spaced out by nops
    task automatic forwardingTest();
        mipsPkg::word_t x, y;
        x = $urandom();
        y = fillPattern(32'h0000_0180);
        for (int pass = 0; pass < 2; pass++)
        begin
            clearProgram(pass == 0 ? 0 : 3);
            loadConst(5'd1, x);
            emit(encI(mipsPkg::opAddi, 5'd2, 5'd1, 16'h0005));
            emit(encR(mipsPkg::fnAdd, 5'd3, 5'd2, 5'd1));
            emit(encR(mipsPkg::fnSub, 5'd4, 5'd3, 5'd2));
            storeAndExpect(5'd4, 16'h0140, x);
            storeAndExpect(5'd3, 16'h0144, x + x + 32'd5);
            emit(encI(mipsPkg::opLw, 5'd5, 5'd0, 16'h0180));
            emit(encR(mipsPkg::fnAdd, 5'd6, 5'd5, 5'd1));    // load-use
            storeAndExpect(5'd6, 16'h0148, y + x);
            emit(encI(mipsPkg::opLw, 5'd7, 5'd0, 16'h0180));
            storeAndExpect(5'd7, 16'h014C, y);
            emit(encHalt());
            runProgram(pass == 0 ? "back-to-back" : "spaced");
        end
    endtask

    task automatic controlFlowTest();
        clearProgram(0);
        emit(encI(mipsPkg::opAddi, 5'd1, 5'd0, 16'h0007));
        emit(encI(mipsPkg::opAddi, 5'd2, 5'd0, 16'h0007));
        emit(encI(mipsPkg::opBeq, 5'd2, 5'd1, 16'h0002));    // taken, to word 5
        emit(encI(mipsPkg::opSw, 5'd1, 5'd0, 16'h0200));    // squashed
        emit(encI(mipsPkg::opSw, 5'd1, 5'd0, 16'h0204));
        emit(encI(mipsPkg::opAddi, 5'd3, 5'd0, 16'h0009));
        emit(encI(mipsPkg::opBeq, 5'd3, 5'd1, 16'h0001));    // not taken
        storeAndExpect(5'd3, 16'h0208, 32'd9);
        emit(encJ(resetVector + 32'd44));
        emit(encI(mipsPkg::opSw, 5'd3, 5'd0, 16'h020C));    // squashed
        emit(encI(mipsPkg::opSw, 5'd3, 5'd0, 16'h0210));
        storeAndExpect(5'd1, 16'h0214, 32'd7);    // word 11, jump target
        emit(encHalt());
        runProgram("control flow");
    endtask

    task automatic ledTest(input logic [ledCount-1:0] pattern);
        logic [15:0] value;
        clearProgram(0);
        emit(encI(mipsPkg::opLui, 5'd1, 5'd0, 16'h8000));
        for (int k = 0; k < ledCount; k++)
        begin
            value = {15'($urandom()), pattern[k]};    // only bit 0 counts
            emit(encI(mipsPkg::opAddi, 5'd2, 5'd0, value));
            emit(encI(mipsPkg::opSw, 5'd2, 5'd1, 16'(4 * k)));
        end
        emit(encI(mipsPkg::opLw, 5'd5, 5'd1, 16'h0004));
        storeAndExpect(5'd5, 16'h0240, 32'd0);    // led region reads zero
        emit(encHalt());
        runProgram("led");
        checkLed("led", led, pattern);
    endtask

    task automatic haltResetTest();
        clearProgram(0);
        emit(encI(mipsPkg::opAddi, 5'd1, 5'd0, 16'h0055));
        storeAndExpect(5'd1, 16'h0280, 32'h0000_0055);
        emit(encHalt());
        emit(encI(mipsPkg::opSw, 5'd1, 5'd0, 16'h0284));    // never executes
        emit(encI(mipsPkg::opSw, 5'd1, 5'd0, 16'h0288));
        runProgram("halt");
    endtask

    initial
    begin
        logic [ledCount-1:0] ledPattern;
        reset      = 1'b1;
        mismatches = 0;
        failures   = 0;
        logStart   = 0;
        void'($urandom(32'h807d));
        clearProgram(0);

        arithmeticTest();
        forwardingTest();
        controlFlowTest();
        ledPattern = ledCount'($urandom());
        ledTest(ledPattern);
        ledTest(~ledPattern);
        haltResetTest();

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* mipsSystem.f */
+incdir+include
logic/mipsPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/hazardUnit.sv
logic/mipsSystem.sv
test/tbMipsSystem.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, verdict taken from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mipsSystem.f --top-module tbMipsSystem \
    -Mdir obj_dir -o simMipsSystem
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simMipsSystem > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" sim.log; then
    exit 0
fi
exit 1
